// ==== hw/axil_bus_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////
// AXI-lite bus definitions seen by the monitor
////////////////////////////////////////////////////////////

package axil_bus_pkg;

	// BRESP and RRESP width
	localparam int unsigned RESP_WIDTH = 2;

	// Response codes
	localparam logic [RESP_WIDTH-1:0] RESP_OKAY = 2'b00;
	// Exclusive okay, never legal on AXI-lite
	localparam logic [RESP_WIDTH-1:0] RESP_EXOKAY = 2'b01;
	localparam logic [RESP_WIDTH-1:0] RESP_SLVERR = 2'b10;
	localparam logic [RESP_WIDTH-1:0] RESP_DECERR = 2'b11;

endpackage

`default_nettype wire

// ==== hw/axil_mon_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////
// Monitor limits and violation encoding
////////////////////////////////////////////////////////////

package axil_mon_pkg;

	// Outstanding counter width and highest legal count
	localparam int unsigned LG_DEPTH = 4;
	localparam int unsigned MAX_OUTSTANDING = 14;

	// Timeout limits, in consecutive sampled cycles
	localparam int unsigned MAX_WAIT = 12;
	localparam int unsigned MAX_RSTALL = 12;
	localparam int unsigned MAX_DELAY = 12;
	localparam int unsigned TIMER_WIDTH = 4;

	// Violation vector size
	localparam int unsigned VIO_COUNT = 12;
	localparam int unsigned VIO_IDX_WIDTH = 4;

	// Violation bit positions, lowest index wins as first
	localparam int unsigned VIO_RESP_IN_RESET = 0;
	localparam int unsigned VIO_BRESP_EXOKAY = 1;
	localparam int unsigned VIO_RRESP_EXOKAY = 2;
	localparam int unsigned VIO_DEPTH = 3;
	localparam int unsigned VIO_ORPHAN_RESP = 4;
	localparam int unsigned VIO_AW_WAIT = 5;
	localparam int unsigned VIO_W_WAIT = 6;
	localparam int unsigned VIO_AR_WAIT = 7;
	localparam int unsigned VIO_B_STALL = 8;
	localparam int unsigned VIO_R_STALL = 9;
	localparam int unsigned VIO_WR_DELAY = 10;
	localparam int unsigned VIO_RD_DELAY = 11;

endpackage

`default_nettype wire

// ==== hw/axil_event_if.sv ====
`default_nettype none
`timescale 1ns/1ps

// Per-cycle handshake events from the decoder
interface axil_event_if;

	// Request handshakes, valid and ready together
	logic aw_req;
	logic w_req;
	logic ar_req;

	// Response handshakes
	logic b_ack;
	logic r_ack;

	// Raw response valids, used to excuse waits
	logic bvalid;
	logic rvalid;

	// Valid held while ready is low
	logic aw_stall;
	logic w_stall;
	logic ar_stall;
	logic b_stall;
	logic r_stall;

	modport source (
		output aw_req, w_req, ar_req, b_ack, r_ack, bvalid, rvalid,
		output aw_stall, w_stall, ar_stall, b_stall, r_stall
	);

	// Counters only need the strobes
	modport counter (input aw_req, w_req, ar_req, b_ack, r_ack);

	modport watch (input aw_stall, w_stall, ar_stall, b_stall, r_stall, bvalid, rvalid);

endinterface

`default_nettype wire

// ==== hw/axil_event_decode.sv ====
`default_nettype none
`timescale 1ns/1ps

module axil_event_decode (
	input wire i_clk,
	input wire i_axi_reset_n,
	input wire i_axi_awvalid,
	input wire i_axi_awready,
	input wire i_axi_wvalid,
	input wire i_axi_wready,
	input wire i_axi_bvalid,
	input wire i_axi_bready,
	input wire [axil_bus_pkg::RESP_WIDTH-1:0] i_axi_bresp,
	input wire i_axi_arvalid,
	input wire i_axi_arready,
	input wire i_axi_rvalid,
	input wire i_axi_rready,
	input wire [axil_bus_pkg::RESP_WIDTH-1:0] i_axi_rresp,
	axil_event_if.source ev,
	output logic [2:0] o_vio
);
	import axil_bus_pkg::*;

	// High on the cycle right after reset was sampled low
	logic r_after_reset;

	// Only the exclusive-okay code is reserved
	function automatic logic resp_is_exokay(input logic [RESP_WIDTH-1:0] resp);
		logic hit;
		case (resp)
			RESP_OKAY, RESP_SLVERR, RESP_DECERR: hit = 1'b0;
			RESP_EXOKAY: hit = 1'b1;
			default: hit = 1'b0;
		endcase
		return hit;
	endfunction

	////////////////////////////////////////////////////////////
	// Handshake and stall strobes
	////////////////////////////////////////////////////////////

	assign ev.aw_req = i_axi_awvalid && i_axi_awready;
	assign ev.w_req = i_axi_wvalid && i_axi_wready;
	assign ev.ar_req = i_axi_arvalid && i_axi_arready;
	assign ev.b_ack = i_axi_bvalid && i_axi_bready;
	assign ev.r_ack = i_axi_rvalid && i_axi_rready;
	assign ev.bvalid = i_axi_bvalid;
	assign ev.rvalid = i_axi_rvalid;
	assign ev.aw_stall = i_axi_awvalid && !i_axi_awready;
	assign ev.w_stall = i_axi_wvalid && !i_axi_wready;
	assign ev.ar_stall = i_axi_arvalid && !i_axi_arready;
	assign ev.b_stall = i_axi_bvalid && !i_axi_bready;
	assign ev.r_stall = i_axi_rvalid && !i_axi_rready;

	////////////////////////////////////////////////////////////
	// Response checks
	////////////////////////////////////////////////////////////

	// Track reset, one cycle late
	always_ff @(posedge i_clk)
		r_after_reset <= !i_axi_reset_n;

	// Any response valid in reset or on the first cycle out of it
	assign o_vio[0] = (i_axi_bvalid || i_axi_rvalid) && (!i_axi_reset_n || r_after_reset);
	assign o_vio[1] = i_axi_bvalid && resp_is_exokay(i_axi_bresp);
	assign o_vio[2] = i_axi_rvalid && resp_is_exokay(i_axi_rresp);

endmodule

`default_nettype wire

// ==== hw/axil_txn_counter.sv ====
`default_nettype none
`timescale 1ns/1ps

module axil_txn_counter (
	input wire i_clk,
	input wire i_axi_reset_n,
	axil_event_if.counter ev,
	output logic [axil_mon_pkg::LG_DEPTH-1:0] o_awr_outstanding,
	output logic [axil_mon_pkg::LG_DEPTH-1:0] o_wr_outstanding,
	output logic [axil_mon_pkg::LG_DEPTH-1:0] o_rd_outstanding,
	output logic [1:0] o_vio
);
	import axil_mon_pkg::*;

	// Overflow conditions per channel
	logic awr_full_req;
	logic wr_full_req;
	logic rd_full_req;

	// Next count from request and response strobes
	function automatic logic [LG_DEPTH-1:0] next_count(
		input logic [LG_DEPTH-1:0] cnt,
		input logic inc,
		input logic dec
	);
		logic [LG_DEPTH-1:0] nxt;
		nxt = cnt;
		// Request past the limit, count freezes
		if (inc && (cnt == MAX_OUTSTANDING))
			nxt = cnt;
		// Response with nothing to retire, stay at zero
		else if (dec && (cnt == '0))
			nxt = cnt;
		else if (inc && !dec)
			nxt = cnt + 1'b1;
		else if (dec && !inc)
			nxt = cnt - 1'b1;
		return nxt;
	endfunction

	////////////////////////////////////////////////////////////
	// Outstanding counters
	////////////////////////////////////////////////////////////

	// Both write counters retire on B, read retires on R
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_awr_outstanding <= '0;
			o_wr_outstanding <= '0;
			o_rd_outstanding <= '0;
		end
		else
		begin
			o_awr_outstanding <= next_count(o_awr_outstanding, ev.aw_req, ev.b_ack);
			o_wr_outstanding <= next_count(o_wr_outstanding, ev.w_req, ev.b_ack);
			o_rd_outstanding <= next_count(o_rd_outstanding, ev.ar_req, ev.r_ack);
		end
	end

	////////////////////////////////////////////////////////////
	// Depth and orphan checks
	////////////////////////////////////////////////////////////

	assign awr_full_req = ev.aw_req && (o_awr_outstanding == MAX_OUTSTANDING);
	assign wr_full_req = ev.w_req && (o_wr_outstanding == MAX_OUTSTANDING);
	assign rd_full_req = ev.ar_req && (o_rd_outstanding == MAX_OUTSTANDING);

	// Depth overflow on any channel
	assign o_vio[0] = awr_full_req || wr_full_req || rd_full_req;

	// A write response needs both address and data outstanding
	assign o_vio[1] = (ev.b_ack && ((o_awr_outstanding == '0) || (o_wr_outstanding == '0)))
		|| (ev.r_ack && (o_rd_outstanding == '0));

endmodule

`default_nettype wire

// ==== hw/axil_timeout_watch.sv ====
`default_nettype none
`timescale 1ns/1ps

module axil_timeout_watch (
	input wire i_clk,
	input wire i_axi_reset_n,
	axil_event_if.watch ev,
	input wire [axil_mon_pkg::LG_DEPTH-1:0] i_awr_outstanding,
	input wire [axil_mon_pkg::LG_DEPTH-1:0] i_wr_outstanding,
	input wire [axil_mon_pkg::LG_DEPTH-1:0] i_rd_outstanding,
	output logic [6:0] o_vio
);
	import axil_mon_pkg::*;

	// Timer order matches o_vio
	// 0 AW wait, 1 W wait, 2 AR wait
	// 3 B stall, 4 R stall
	// 5 write delay, 6 read delay
	logic [6:0] timer_run;
	logic [TIMER_WIDTH-1:0] r_timer [7];

	// Limit for each timer slot
	function automatic int unsigned timer_limit(input int idx);
		int unsigned lim;
		if (idx < 3)
			lim = MAX_WAIT;
		else if (idx < 5)
			lim = MAX_RSTALL;
		else
			lim = MAX_DELAY;
		return lim;
	endfunction

	////////////////////////////////////////////////////////////
	// Conditions that keep each timer running
	////////////////////////////////////////////////////////////

	always_comb
	begin
		// Write requests are excused while a write response is pending
		timer_run[0] = ev.aw_stall && !ev.bvalid;
		timer_run[1] = ev.w_stall && !ev.bvalid;
		// Read requests are excused while a read response is pending
		timer_run[2] = ev.ar_stall && !ev.rvalid;
		// Responses held back by the master
		timer_run[3] = ev.b_stall;
		timer_run[4] = ev.r_stall;
		// Write needs both address and data before a response is owed
		timer_run[5] = (i_awr_outstanding != '0) && (i_wr_outstanding != '0)
			&& !ev.bvalid;
		timer_run[6] = (i_rd_outstanding != '0) && !ev.rvalid;
	end

	////////////////////////////////////////////////////////////
	// Timers
	////////////////////////////////////////////////////////////

	// Clear on a lapse, saturate one below the limit
	always_ff @(posedge i_clk)
	begin
		for (int i = 0; i < 7; i++)
		begin
			if (!i_axi_reset_n)
				r_timer[i] <= '0;
			else if (!timer_run[i])
				r_timer[i] <= '0;
			else if (r_timer[i] != TIMER_WIDTH'(timer_limit(i) - 1))
				r_timer[i] <= r_timer[i] + 1'b1;
		end
	end

	// Flag on the cycle that completes the limit
	always_comb
	begin
		for (int i = 0; i < 7; i++)
			o_vio[i] = timer_run[i] && (r_timer[i] == TIMER_WIDTH'(timer_limit(i) - 1));
	end

endmodule

`default_nettype wire

// ==== hw/axil_violation_log.sv ====
`default_nettype none
`timescale 1ns/1ps

module axil_violation_log (
	input wire i_clk,
	input wire i_axi_reset_n,
	input wire [axil_mon_pkg::VIO_COUNT-1:0] i_vio,
	output logic [axil_mon_pkg::VIO_COUNT-1:0] o_violation,
	output logic [axil_mon_pkg::VIO_IDX_WIDTH-1:0] o_first_violation,
	output logic o_violation_valid
);
	import axil_mon_pkg::*;

	// Lowest pulsing index this cycle
	logic [VIO_IDX_WIDTH-1:0] lowest_idx;

	// Scan downward so the lowest set bit wins
	always_comb
	begin
		lowest_idx = '0;
		for (int i = VIO_COUNT - 1; i >= 0; i--)
		begin
			if (i_vio[i])
				lowest_idx = VIO_IDX_WIDTH'(i);
		end
	end

	////////////////////////////////////////////////////////////
	// Sticky flags and first capture
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_violation <= '0;
			o_first_violation <= '0;
			o_violation_valid <= 1'b0;
		end
		else
		begin
			o_violation <= o_violation | i_vio;
			// Capture once, hold until reset
			if (!o_violation_valid && (|i_vio))
			begin
				o_first_violation <= lowest_idx;
				o_violation_valid <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/axil_protocol_monitor.sv ====
`default_nettype none
`timescale 1ns/1ps

module axil_protocol_monitor (
	input wire i_clk,
	input wire i_axi_reset_n,
	input wire i_axi_awvalid,
	input wire i_axi_awready,
	input wire i_axi_wvalid,
	input wire i_axi_wready,
	input wire i_axi_bvalid,
	input wire i_axi_bready,
	input wire [axil_bus_pkg::RESP_WIDTH-1:0] i_axi_bresp,
	input wire i_axi_arvalid,
	input wire i_axi_arready,
	input wire i_axi_rvalid,
	input wire i_axi_rready,
	input wire [axil_bus_pkg::RESP_WIDTH-1:0] i_axi_rresp,
	output wire [axil_mon_pkg::LG_DEPTH-1:0] o_awr_outstanding,
	output wire [axil_mon_pkg::LG_DEPTH-1:0] o_wr_outstanding,
	output wire [axil_mon_pkg::LG_DEPTH-1:0] o_rd_outstanding,
	output wire [axil_mon_pkg::VIO_COUNT-1:0] o_violation,
	output wire [axil_mon_pkg::VIO_IDX_WIDTH-1:0] o_first_violation,
	output wire o_violation_valid
);
	import axil_mon_pkg::*;

	// Pulse vectors from each checker
	wire [2:0] decode_vio;
	wire [1:0] count_vio;
	wire [6:0] watch_vio;
	wire [VIO_COUNT-1:0] all_vio;

	axil_event_if ev ();

	////////////////////////////////////////////////////////////
	// Event decode and counting
	////////////////////////////////////////////////////////////

	axil_event_decode axil_event_decode_i (
		.i_clk(i_clk),
		.i_axi_reset_n(i_axi_reset_n),
		.i_axi_awvalid(i_axi_awvalid),
		.i_axi_awready(i_axi_awready),
		.i_axi_wvalid(i_axi_wvalid),
		.i_axi_wready(i_axi_wready),
		.i_axi_bvalid(i_axi_bvalid),
		.i_axi_bready(i_axi_bready),
		.i_axi_bresp(i_axi_bresp),
		.i_axi_arvalid(i_axi_arvalid),
		.i_axi_arready(i_axi_arready),
		.i_axi_rvalid(i_axi_rvalid),
		.i_axi_rready(i_axi_rready),
		.i_axi_rresp(i_axi_rresp),
		.ev(ev.source),
		.o_vio(decode_vio)
	);

	axil_txn_counter axil_txn_counter_i (
		.i_clk(i_clk),
		.i_axi_reset_n(i_axi_reset_n),
		.ev(ev.counter),
		.o_awr_outstanding(o_awr_outstanding),
		.o_wr_outstanding(o_wr_outstanding),
		.o_rd_outstanding(o_rd_outstanding),
		.o_vio(count_vio)
	);

	// Timers see the registered counts
	axil_timeout_watch axil_timeout_watch_i (
		.i_clk(i_clk),
		.i_axi_reset_n(i_axi_reset_n),
		.ev(ev.watch),
		.i_awr_outstanding(o_awr_outstanding),
		.i_wr_outstanding(o_wr_outstanding),
		.i_rd_outstanding(o_rd_outstanding),
		.o_vio(watch_vio)
	);

	////////////////////////////////////////////////////////////
	// Violation vector in bit-position order
	////////////////////////////////////////////////////////////

	assign all_vio[VIO_RESP_IN_RESET] = decode_vio[0];
	assign all_vio[VIO_BRESP_EXOKAY] = decode_vio[1];
	assign all_vio[VIO_RRESP_EXOKAY] = decode_vio[2];
	assign all_vio[VIO_DEPTH] = count_vio[0];
	assign all_vio[VIO_ORPHAN_RESP] = count_vio[1];
	assign all_vio[VIO_AW_WAIT] = watch_vio[0];
	assign all_vio[VIO_W_WAIT] = watch_vio[1];
	assign all_vio[VIO_AR_WAIT] = watch_vio[2];
	assign all_vio[VIO_B_STALL] = watch_vio[3];
	assign all_vio[VIO_R_STALL] = watch_vio[4];
	assign all_vio[VIO_WR_DELAY] = watch_vio[5];
	assign all_vio[VIO_RD_DELAY] = watch_vio[6];

	axil_violation_log axil_violation_log_i (
		.i_clk(i_clk),
		.i_axi_reset_n(i_axi_reset_n),
		.i_vio(all_vio),
		.o_violation(o_violation),
		.o_first_violation(o_first_violation),
		.o_violation_valid(o_violation_valid)
	);

endmodule

`default_nettype wire

// ==== tests/axil_protocol_monitor_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_protocol_monitor_checker (
	input wire i_clk,
	input wire i_axi_reset_n,
	input wire [axil_mon_pkg::LG_DEPTH-1:0] i_awr_outstanding,
	input wire [axil_mon_pkg::LG_DEPTH-1:0] i_wr_outstanding,
	input wire [axil_mon_pkg::LG_DEPTH-1:0] i_rd_outstanding,
	input wire [axil_mon_pkg::VIO_COUNT-1:0] i_violation,
	input wire [axil_mon_pkg::VIO_IDX_WIDTH-1:0] i_first_violation,
	input wire i_violation_valid
);
	import axil_mon_pkg::*;

	// No counter passes the legal depth
	count_in_range: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(i_awr_outstanding <= LG_DEPTH'(MAX_OUTSTANDING))
		&& (i_wr_outstanding <= LG_DEPTH'(MAX_OUTSTANDING))
		&& (i_rd_outstanding <= LG_DEPTH'(MAX_OUTSTANDING)))
		else $error("outstanding count above the legal depth");

	// Set flags stay set until reset
	flags_sticky: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		$past(i_axi_reset_n) |-> ((i_violation & $past(i_violation)) == $past(i_violation)))
		else $error("a violation flag was lost outside reset");

	// First index frozen once captured
	first_held: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		($past(i_axi_reset_n) && $past(i_violation_valid)) |-> $stable(i_first_violation))
		else $error("first violation index changed after capture");

endmodule

// Attach to every monitor top level
bind axil_protocol_monitor axil_protocol_monitor_checker axil_protocol_monitor_checker_i (
	.i_clk(i_clk),
	.i_axi_reset_n(i_axi_reset_n),
	.i_awr_outstanding(o_awr_outstanding),
	.i_wr_outstanding(o_wr_outstanding),
	.i_rd_outstanding(o_rd_outstanding),
	.i_violation(o_violation),
	.i_first_violation(o_first_violation),
	.i_violation_valid(o_violation_valid)
);

`default_nettype wire

// ==== tests/tb_axil_protocol_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axil_protocol_monitor;
	import axil_bus_pkg::*;
	import axil_mon_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam logic [31:0] SEED = 32'h7c5;
	localparam int RESET_CYCLES = 16;
	// Longest random idle gap
	localparam int GAP_MAX = 8;
	localparam string DATA_FILE = "tests/axil_monitor_testdata.txt";

	logic i_clk;
	logic i_axi_reset_n;
	logic i_axi_awvalid;
	logic i_axi_awready;
	logic i_axi_wvalid;
	logic i_axi_wready;
	logic i_axi_bvalid;
	logic i_axi_bready;
	logic [RESP_WIDTH-1:0] i_axi_bresp;
	logic i_axi_arvalid;
	logic i_axi_arready;
	logic i_axi_rvalid;
	logic i_axi_rready;
	logic [RESP_WIDTH-1:0] i_axi_rresp;
	wire [LG_DEPTH-1:0] o_awr_outstanding;
	wire [LG_DEPTH-1:0] o_wr_outstanding;
	wire [LG_DEPTH-1:0] o_rd_outstanding;
	wire [VIO_COUNT-1:0] o_violation;
	wire [VIO_IDX_WIDTH-1:0] o_first_violation;
	wire o_violation_valid;

	// One entry per data line
	// Repeat count 0 marks a random gap
	int rep_q[$];
	logic [14:0] stim_q[$];
	logic [LG_DEPTH-1:0] exp_awr_q[$];
	logic [LG_DEPTH-1:0] exp_wr_q[$];
	logic [LG_DEPTH-1:0] exp_rd_q[$];
	logic [VIO_COUNT-1:0] exp_vio_q[$];
	logic [VIO_IDX_WIDTH-1:0] exp_first_q[$];
	logic exp_valid_q[$];

	// Watchdog length is known once the data is loaded
	int budget_cycles;
	logic budget_ready = 1'b0;

	axil_protocol_monitor axil_protocol_monitor_i (
		.i_clk(i_clk),
		.i_axi_reset_n(i_axi_reset_n),
		.i_axi_awvalid(i_axi_awvalid),
		.i_axi_awready(i_axi_awready),
		.i_axi_wvalid(i_axi_wvalid),
		.i_axi_wready(i_axi_wready),
		.i_axi_bvalid(i_axi_bvalid),
		.i_axi_bready(i_axi_bready),
		.i_axi_bresp(i_axi_bresp),
		.i_axi_arvalid(i_axi_arvalid),
		.i_axi_arready(i_axi_arready),
		.i_axi_rvalid(i_axi_rvalid),
		.i_axi_rready(i_axi_rready),
		.i_axi_rresp(i_axi_rresp),
		.o_awr_outstanding(o_awr_outstanding),
		.o_wr_outstanding(o_wr_outstanding),
		.o_rd_outstanding(o_rd_outstanding),
		.o_violation(o_violation),
		.o_first_violation(o_first_violation),
		.o_violation_valid(o_violation_valid)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	////////////////////////////////////////////////////////////
	// Failure and compare helpers
	////////////////////////////////////////////////////////////

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	task automatic check_count(input string name, input logic [LG_DEPTH-1:0] expected,
		input logic [LG_DEPTH-1:0] actual);
		if (actual !== expected)
			fail_run($sformatf("Error at %0t: %s expected %0d, got %0d",
				$time, name, expected, actual));
	endtask

	task automatic check_violation(input string name, input logic [VIO_COUNT-1:0] expected,
		input logic [VIO_COUNT-1:0] actual);
		if (actual !== expected)
			fail_run($sformatf("Error at %0t: %s expected %03h, got %03h",
				$time, name, expected, actual));
	endtask

	task automatic check_index(input string name, input logic [VIO_IDX_WIDTH-1:0] expected,
		input logic [VIO_IDX_WIDTH-1:0] actual);
		if (actual !== expected)
			fail_run($sformatf("Error at %0t: %s expected %0d, got %0d",
				$time, name, expected, actual));
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			fail_run($sformatf("Error at %0t: %s expected %0b, got %0b",
				$time, name, expected, actual));
	endtask

	// All outputs against one data line
	task automatic check_line(input int idx);
		check_count("o_awr_outstanding", exp_awr_q[idx], o_awr_outstanding);
		check_count("o_wr_outstanding", exp_wr_q[idx], o_wr_outstanding);
		check_count("o_rd_outstanding", exp_rd_q[idx], o_rd_outstanding);
		check_violation("o_violation", exp_vio_q[idx], o_violation);
		check_index("o_first_violation", exp_first_q[idx], o_first_violation);
		check_flag("o_violation_valid", exp_valid_q[idx], o_violation_valid);
	endtask

	////////////////////////////////////////////////////////////
	// Data file loading and stimulus
	////////////////////////////////////////////////////////////

	task automatic load_testdata();
		int fd;
		int n;
		string line;
		int rep;
		logic rst;
		logic [1:0] aw;
		logic [1:0] w;
		logic [1:0] b;
		logic [1:0] ar;
		logic [1:0] r;
		logic [RESP_WIDTH-1:0] bresp;
		logic [RESP_WIDTH-1:0] rresp;
		logic [LG_DEPTH-1:0] e_awr;
		logic [LG_DEPTH-1:0] e_wr;
		logic [LG_DEPTH-1:0] e_rd;
		logic [VIO_COUNT-1:0] e_vio;
		logic [VIO_IDX_WIDTH-1:0] e_first;
		logic e_valid;
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0)
			fail_run("Could not open the test data file");
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				// Skip blank lines and column notes
				if ((line.len() > 1) && (line.getc(0) != "#"))
				begin
					n = $sscanf(line, "%d %b %b %b %b %b %b %d %d %d %d %d %h %d %b",
						rep, rst, aw, w, b, ar, r, bresp, rresp,
						e_awr, e_wr, e_rd, e_vio, e_first, e_valid);
					if (n != 15)
						fail_run("A line of the test data file could not be parsed");
					rep_q.push_back(rep);
					stim_q.push_back({rst, aw, w, b, ar, r, bresp, rresp});
					exp_awr_q.push_back(e_awr);
					exp_wr_q.push_back(e_wr);
					exp_rd_q.push_back(e_rd);
					exp_vio_q.push_back(e_vio);
					exp_first_q.push_back(e_first);
					exp_valid_q.push_back(e_valid);
				end
			end
			$fclose(fd);
		end
	endtask

	// Inputs change only on the rising edge
	task automatic apply_stim(input logic [14:0] stim);
		i_axi_reset_n <= stim[14];
		{i_axi_awvalid, i_axi_awready} <= stim[13:12];
		{i_axi_wvalid, i_axi_wready} <= stim[11:10];
		{i_axi_bvalid, i_axi_bready} <= stim[9:8];
		{i_axi_arvalid, i_axi_arready} <= stim[7:6];
		{i_axi_rvalid, i_axi_rready} <= stim[5:4];
		i_axi_bresp <= stim[3:2];
		i_axi_rresp <= stim[1:0];
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		int cycles;
		apply_stim('0);
		void'($urandom(SEED));
		load_testdata();
		budget_cycles = RESET_CYCLES + 64;
		foreach (rep_q[i])
			budget_cycles += (rep_q[i] == 0) ? GAP_MAX : rep_q[i];
		budget_ready = 1'b1;
		// Reset is low from time zero and the loop supplies its last edge
		repeat (RESET_CYCLES - 1) @(posedge i_clk);
		for (int i = 0; i < rep_q.size(); i++)
		begin
			cycles = (rep_q[i] == 0) ? $urandom_range(GAP_MAX, 1) : rep_q[i];
			for (int c = 0; c < cycles; c++)
			begin
				@(posedge i_clk);
				apply_stim(stim_q[i]);
				// Previous line was sampled on this edge
				if ((c == 0) && (i > 0))
				begin
					@(negedge i_clk);
					check_line(i - 1);
				end
			end
		end
		@(posedge i_clk);
		@(negedge i_clk);
		check_line(rep_q.size() - 1);
		$display("TEST PASSED");
		$finish;
	end

	// Watchdog
	initial
	begin
		wait (budget_ready);
		repeat (budget_cycles) @(posedge i_clk);
		fail_run("Watchdog expired before the test data was finished");
	end

endmodule

`default_nettype wire

// ==== build.f ====
hw/axil_bus_pkg.sv
hw/axil_mon_pkg.sv
hw/axil_event_if.sv
hw/axil_event_decode.sv
hw/axil_txn_counter.sv
hw/axil_timeout_watch.sv
hw/axil_violation_log.sv
hw/axil_protocol_monitor.sv
tests/axil_protocol_monitor_checker.sv
tests/tb_axil_protocol_monitor.sv

// ==== Makefile ====
# Verilator build for the AXI-lite protocol monitor testbench

VERILATOR ?= verilator
TOP ?= tb_axil_protocol_monitor
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIM ?= $(OBJ_DIR)/V$(TOP)
DATA ?= tests/axil_monitor_testdata.txt

SOURCES := $(wildcard hw/*.sv tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulator exits non-zero on any $fatal or failed assertion
run: $(SIM) $(DATA)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/axil_monitor_testdata.txt ====
# rep rst aw w b ar r bresp rresp, then expected awr wr rd vio(hex) first valid
# pairs are valid,ready; rep 0 is an idle gap of random length
1 1 00 00 00 00 00 0 0 0 0 0 000 0 0
2 1 11 00 00 00 00 0 0 2 0 0 000 0 0
1 1 11 11 00 11 00 0 0 3 1 1 000 0 0
2 1 00 11 00 10 00 0 0 3 3 1 000 0 0
1 1 00 00 11 00 11 0 0 2 2 0 000 0 0
1 1 11 00 11 00 00 0 0 2 1 0 000 0 0
2 1 00 00 10 00 00 0 0 2 1 0 000 0 0
1 1 00 00 11 00 00 0 0 1 0 0 000 0 0
1 1 00 11 00 00 00 0 0 1 1 0 000 0 0
3 1 00 00 00 00 00 0 0 1 1 0 000 0 0
1 1 00 00 11 00 00 0 0 0 0 0 000 0 0
0 1 00 00 00 00 00 0 0 0 0 0 000 0 0
1 1 00 00 10 00 00 1 0 0 0 0 002 1 1
1 1 00 00 00 00 10 0 1 0 0 0 006 1 1
2 0 00 00 00 00 00 0 0 0 0 0 000 0 0
1 1 00 00 00 00 10 0 0 0 0 0 001 0 1
1 1 00 00 00 00 00 0 0 0 0 0 001 0 1
2 0 00 00 00 00 00 0 0 0 0 0 000 0 0
1 1 00 00 00 00 00 0 0 0 0 0 000 0 0
0 1 00 00 00 00 00 0 0 0 0 0 000 0 0
14 1 11 00 00 00 00 0 0 14 0 0 000 0 0
1 1 11 00 00 00 00 0 0 14 0 0 008 3 1
2 0 00 00 00 00 00 0 0 0 0 0 000 0 0
1 1 00 00 00 00 00 0 0 0 0 0 000 0 0
1 1 00 00 11 00 00 0 0 0 0 0 010 4 1
2 0 00 00 00 00 00 0 0 0 0 0 000 0 0
1 1 00 00 00 00 00 0 0 0 0 0 000 0 0
0 1 00 00 00 00 00 0 0 0 0 0 000 0 0
11 1 10 00 00 00 00 0 0 0 0 0 000 0 0
1 1 10 00 00 00 00 0 0 0 0 0 020 5 1
2 0 00 00 00 00 00 0 0 0 0 0 000 0 0
1 1 00 00 00 00 00 0 0 0 0 0 000 0 0
1 1 11 11 00 00 00 0 0 1 1 0 000 0 0
11 1 10 00 10 00 00 0 0 1 1 0 000 0 0
1 1 10 00 11 00 00 0 0 0 0 0 000 0 0
1 1 00 00 00 00 00 0 0 0 0 0 000 0 0
11 1 00 00 00 00 10 0 0 0 0 0 000 0 0
1 1 00 00 00 00 10 0 0 0 0 0 200 9 1
2 0 00 00 00 00 00 0 0 0 0 0 000 0 0
1 1 00 00 00 00 00 0 0 0 0 0 000 0 0
0 1 00 00 00 00 00 0 0 0 0 0 000 0 0
1 1 00 00 00 11 00 0 0 0 0 1 000 0 0
11 1 00 00 00 00 00 0 0 0 0 1 000 0 0
1 1 00 00 00 00 00 0 0 0 0 1 800 11 1
1 1 00 00 00 00 11 0 0 0 0 0 800 11 1
2 0 00 00 00 00 00 0 0 0 0 0 000 0 0
1 1 00 00 00 00 00 0 0 0 0 0 000 0 0
1 1 00 00 10 00 10 1 1 0 0 0 006 1 1
1 1 00 00 11 00 00 0 0 0 0 0 016 1 1
2 0 00 00 00 00 00 0 0 0 0 0 000 0 0
1 1 00 00 00 00 00 0 0 0 0 0 000 0 0
